// File: sap_datapath.f
logic/arch_defs_pkg.sv
logic/isa_defs_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/exec_ctrl.sv
logic/sap_datapath.sv
dv/sap_datapath_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sap_datapath.f \
    --top-module sap_datapath_tb \
    -o sap_datapath_sim

./obj_dir/sap_datapath_sim > sim.log 2>&1
cat sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: dv/sap_datapath_tb.sv
`default_nettype none

module sap_datapath_tb;

    localparam int DW         = arch_defs_pkg::DATA_WIDTH;
    localparam int IW         = isa_defs_pkg::INSTR_WIDTH;
    localparam int XW         = isa_defs_pkg::REG_IDX_WIDTH;
    localparam int MAX_CYCLES = 600; // About 340 cycles of tests plus margin
    localparam logic [DW-1:0] ONE = {{(DW-1){1'b0}}, 1'b1};

    typedef struct packed {
        logic [DW-1:0] result;
        logic          zero;
        logic          carry;
        logic          negative;
    } alu_out_t;

    // One entry per driven cycle, checked at the following falling edge
    typedef struct packed {
        int            stamp;
        logic [2:0]    op;
        logic          valid;
        logic [DW-1:0] result;
        logic          zero;
        logic          carry;
        logic          negative;
    } expect_t;

    logic          clk = 1'b0;
    logic          reset = 1'b1;
    logic          instr_valid_i = 1'b0;
    logic [IW-1:0] instr_i = '0;
    logic [DW-1:0] imm_i = '0;
    logic [DW-1:0] result_o;
    logic          result_valid_o;
    logic          zero_o;
    logic          carry_o;
    logic          negative_o;

    logic [DW-1:0] model_regs [4];
    logic          model_zero = 1'b0;
    logic          model_carry = 1'b0;
    logic          model_neg = 1'b0;
    expect_t       expect_q [$];
    integer        seed = 32'hdebf_c0f9;
    int            cycle_count = 0;
    int            error_count = 0;
    int            check_count = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    int            error_mark = 0;

    sap_datapath #(.DATA_WIDTH(DW)) UUT (
        .clk            (clk),
        .reset          (reset),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .imm_i          (imm_i),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .zero_o         (zero_o),
        .carry_o        (carry_o),
        .negative_o     (negative_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic alu_out_t alu_model(input arch_defs_pkg::alu_op_t op,
                                           input logic [DW-1:0] a,
                                           input logic [DW-1:0] b,
                                           input logic cin);
        alu_out_t    r;
        logic [DW:0] sum;
        r   = '0;
        sum = '0;
        case (op)
            arch_defs_pkg::ALU_ADD: begin
                sum      = {1'b0, a} + {1'b0, b};
                r.result = sum[DW-1:0];
                r.carry  = sum[DW];
            end
            arch_defs_pkg::ALU_ADC: begin
                sum      = {1'b0, a} + {1'b0, b} + {{DW{1'b0}}, cin};
                r.result = sum[DW-1:0];
                r.carry  = sum[DW];
            end
            arch_defs_pkg::ALU_SUB: begin
                r.result = a - b;
                r.carry  = (a >= b); // No borrow
            end
            arch_defs_pkg::ALU_INR: begin
                r.result = a + ONE;
                r.carry  = (a == '1);
            end
            arch_defs_pkg::ALU_DCR: begin
                r.result = a - ONE;
                r.carry  = (a == '0);
            end
            arch_defs_pkg::ALU_AND: r.result = a & b;
            arch_defs_pkg::ALU_OR:  r.result = a | b;
            arch_defs_pkg::ALU_XOR: r.result = a ^ b;
            default: r.result = '0;
        endcase
        r.zero     = (r.result == '0);
        r.negative = r.result[DW-1];
        return r;
    endfunction

    function automatic logic [IW-1:0] make_instr(input arch_defs_pkg::alu_op_t op,
                                                 input logic [XW-1:0] rd,
                                                 input logic [XW-1:0] rs,
                                                 input logic kind);
        logic [IW-1:0] w;
        w = '0;
        w[isa_defs_pkg::OP_MSB:isa_defs_pkg::OP_LSB] = op;
        w[isa_defs_pkg::RD_MSB:isa_defs_pkg::RD_LSB] = rd;
        w[isa_defs_pkg::RS_MSB:isa_defs_pkg::RS_LSB] = rs;
        w[isa_defs_pkg::KIND_BIT] = kind;
        return w;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = $random(seed);
        return w;
    endfunction

    function automatic logic [DW-1:0] rand_byte();
        logic [31:0] w;
        w = $random(seed);
        return w[DW-1:0];
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("FAIL at %0t: %s", $time, msg);
    endtask

    // Drives one cycle and records what the outputs must show after the next edge
    task automatic drive_instr(input logic valid, input arch_defs_pkg::alu_op_t op,
                               input logic [XW-1:0] rd, input logic [XW-1:0] rs,
                               input logic kind, input logic [DW-1:0] imm);
        expect_t  e;
        alu_out_t r;
        @(negedge clk);
        instr_valid_i = valid;
        instr_i       = make_instr(op, rd, rs, kind);
        imm_i         = imm;
        e       = '0;
        e.stamp = cycle_count;
        e.op    = op;
        if (valid && kind) begin
            model_regs[rd] = imm; // Flags untouched by loads
        end else if (valid) begin
            r = alu_model(op, model_regs[rd], model_regs[rs], model_carry);
            model_regs[rd] = r.result;
            model_zero     = r.zero;
            model_carry    = r.carry;
            model_neg      = r.negative;
            e.valid        = 1'b1;
            e.result       = r.result;
        end
        e.zero     = model_zero;
        e.carry    = model_carry;
        e.negative = model_neg;
        expect_q.push_back(e);
    endtask

    task automatic run_alu(input arch_defs_pkg::alu_op_t op,
                           input logic [XW-1:0] rd, input logic [XW-1:0] rs);
        drive_instr(1'b1, op, rd, rs, 1'b0, rand_byte());
    endtask

    task automatic load_reg(input logic [XW-1:0] rd, input logic [DW-1:0] value);
        drive_instr(1'b1, arch_defs_pkg::ALU_ADD, rd, '0, 1'b1, value);
    endtask

    task automatic idle_cycle();
        logic [31:0] w;
        w = rand_word();
        drive_instr(1'b0, arch_defs_pkg::alu_op_t'(w[2:0]), w[4:3], w[6:5], w[7], w[15:8]);
    endtask

    task automatic finish_test(input string name);
        idle_cycle();
        while (expect_q.size() > 0) @(posedge clk); // Wait until all entries are checked
        tests_run++;
        if (error_count == error_mark) begin
            $display("Test %s finished, no errors", name);
        end else begin
            tests_failed++;
            $display("Test %s finished, %0d errors", name, error_count - error_mark);
        end
        error_mark = error_count;
    endtask

    always @(negedge clk) begin : compare_outputs
        expect_t e;
        if (!reset && expect_q.size() > 0 && expect_q[0].stamp < cycle_count) begin
            e = expect_q.pop_front();
            check_count++;
            if (result_valid_o !== e.valid)
                report_error($sformatf("result_valid_o got %b expected %b", result_valid_o,
                                       e.valid));
            if (e.valid && result_o !== e.result)
                report_error($sformatf("op %0d result_o got %h expected %h", e.op, result_o,
                                       e.result));
            if ({zero_o, carry_o, negative_o} !== {e.zero, e.carry, e.negative})
                report_error($sformatf("flags zcn got %b%b%b expected %b%b%b", zero_o, carry_o,
                                       negative_o, e.zero, e.carry, e.negative));
        end
    end

    initial begin
        logic [31:0] w;
        for (int i = 0; i < 4; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;

        // Reset state and loads
        @(negedge clk);
        if (result_valid_o !== 1'b0 || result_o !== '0 || zero_o !== 1'b0 ||
            carry_o !== 1'b0 || negative_o !== 1'b0)
            report_error("outputs not cleared after reset");
        for (int i = 0; i < 4; i++) begin
            load_reg(XW'(i), rand_byte());
        end
        finish_test("reset_and_load");

        // Carry and borrow corner cases, then random arithmetic
        load_reg(0, 8'hff);
        load_reg(1, 8'h01);
        load_reg(2, 8'h10);
        load_reg(3, 8'h20);
        run_alu(arch_defs_pkg::ALU_ADD, 0, 1);   // ff + 01 wraps and sets carry
        run_alu(arch_defs_pkg::ALU_ADC, 2, 3);   // Picks up that carry
        load_reg(0, 8'h05);
        load_reg(1, 8'h07);
        run_alu(arch_defs_pkg::ALU_SUB, 0, 1);   // Borrow
        load_reg(2, 8'h07);
        load_reg(3, 8'h05);
        run_alu(arch_defs_pkg::ALU_SUB, 2, 3);
        run_alu(arch_defs_pkg::ALU_ADC, 2, 3);
        repeat (8) begin
            load_reg(0, rand_byte());
            load_reg(1, rand_byte());
            w = rand_word();
            case (w[1:0])
                2'd0: run_alu(arch_defs_pkg::ALU_ADD, w[3:2], w[5:4]);
                2'd1: run_alu(arch_defs_pkg::ALU_ADC, w[3:2], w[5:4]);
                default: run_alu(arch_defs_pkg::ALU_SUB, w[3:2], w[5:4]);
            endcase
        end
        finish_test("arithmetic");

        load_reg(1, 8'hff);
        run_alu(arch_defs_pkg::ALU_INR, 1, 0);
        load_reg(2, 8'h00);
        run_alu(arch_defs_pkg::ALU_DCR, 2, 2);
        run_alu(arch_defs_pkg::ALU_INR, 2, 2);
        load_reg(3, 8'h80);
        run_alu(arch_defs_pkg::ALU_DCR, 3, 3);
        finish_test("increment_decrement");

        load_reg(0, 8'hff);
        load_reg(1, 8'h01);
        run_alu(arch_defs_pkg::ALU_ADD, 0, 1);   // Carry set so the logic ops must clear it
        run_alu(arch_defs_pkg::ALU_XOR, 1, 1);
        repeat (12) begin
            load_reg(2, rand_byte());
            w = rand_word();
            case (w[1:0])
                2'd0: run_alu(arch_defs_pkg::ALU_AND, w[3:2], w[5:4]);
                2'd1: run_alu(arch_defs_pkg::ALU_OR, w[3:2], w[5:4]);
                default: run_alu(arch_defs_pkg::ALU_XOR, w[3:2], w[5:4]);
            endcase
        end
        finish_test("logic");

        // Dense stream with about one load per four instructions
        repeat (200) begin
            w = rand_word();
            drive_instr(1'b1, arch_defs_pkg::alu_op_t'(w[2:0]), w[4:3], w[6:5],
                        (w[9:8] == 2'b00), w[23:16]);
        end
        finish_test("back_to_back");

        repeat (5) begin
            w = rand_word();
            run_alu(arch_defs_pkg::alu_op_t'(w[2:0]), w[4:3], w[6:5]);
            repeat (1 + w[9:8]) idle_cycle();
        end
        finish_test("idle_gaps");

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d", tests_run,
                 tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/sap_datapath.sv
`default_nettype none

module sap_datapath #(
    parameter int DATA_WIDTH = arch_defs_pkg::DATA_WIDTH
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 instr_valid_i,
    input  logic [isa_defs_pkg::INSTR_WIDTH-1:0] instr_i,
    input  logic [DATA_WIDTH-1:0]                imm_i,
    output logic [DATA_WIDTH-1:0]                result_o,
    output logic                                 result_valid_o,
    output logic                                 zero_o,
    output logic                                 carry_o,
    output logic                                 negative_o
);

    logic [isa_defs_pkg::REG_IDX_WIDTH-1:0] rd_idx;
    logic [isa_defs_pkg::REG_IDX_WIDTH-1:0] rs_idx;
    logic [isa_defs_pkg::REG_IDX_WIDTH-1:0] wr_idx;
    logic                                   wr_en;
    logic [DATA_WIDTH-1:0]                  wr_data;
    logic [DATA_WIDTH-1:0]                  rd_data;   // First ALU operand
    logic [DATA_WIDTH-1:0]                  rs_data;   // Second ALU operand
    arch_defs_pkg::alu_op_t                 alu_op;
    logic                                   carry_in;
    logic [DATA_WIDTH-1:0]                  alu_result;
    logic                                   alu_zero;
    logic                                   alu_carry;
    logic                                   alu_negative;

    exec_ctrl #(.DATA_WIDTH(DATA_WIDTH)) u_exec_ctrl (
        .clk            (clk),
        .reset          (reset),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .imm_i          (imm_i),
        .alu_result_i   (alu_result),
        .alu_zero_i     (alu_zero),
        .alu_carry_i    (alu_carry),
        .alu_negative_i (alu_negative),
        .rd_idx_o       (rd_idx),
        .rs_idx_o       (rs_idx),
        .wr_idx_o       (wr_idx),
        .wr_en_o        (wr_en),
        .wr_data_o      (wr_data),
        .alu_op_o       (alu_op),
        .carry_in_o     (carry_in),
        .result_valid_o (result_valid_o),
        .zero_o         (zero_o),
        .carry_o        (carry_o),
        .negative_o     (negative_o)
    );

    reg_file #(.DATA_WIDTH(DATA_WIDTH)) u_reg_file (
        .clk       (clk),
        .reset     (reset),
        .rd_idx_i  (rd_idx),
        .rs_idx_i  (rs_idx),
        .wr_idx_i  (wr_idx),
        .wr_en_i   (wr_en),
        .wr_data_i (wr_data),
        .rd_data_o (rd_data),
        .rs_data_o (rs_data)
    );

    // Flags leave through exec_ctrl, the ALU's own flags are only its inputs
    alu #(.DATA_WIDTH(DATA_WIDTH)) u_alu (
        .clk              (clk),
        .reset            (reset),
        .in_one_i         (rd_data),
        .in_two_i         (rs_data),
        .in_carry_i       (carry_in),
        .alu_op_i         (alu_op),
        .result_o         (alu_result),
        .latched_result_o (result_o),
        .zero_o           (alu_zero),
        .carry_o          (alu_carry),
        .negative_o       (alu_negative)
    );

endmodule

`default_nettype wire

// File: logic/exec_ctrl.sv
`default_nettype none

module exec_ctrl #(
    parameter int DATA_WIDTH = arch_defs_pkg::DATA_WIDTH
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   instr_valid_i,
    input  logic [isa_defs_pkg::INSTR_WIDTH-1:0]   instr_i,
    input  logic [DATA_WIDTH-1:0]                  imm_i,
    input  logic [DATA_WIDTH-1:0]                  alu_result_i,
    input  logic                                   alu_zero_i,
    input  logic                                   alu_carry_i,
    input  logic                                   alu_negative_i,
    output logic [isa_defs_pkg::REG_IDX_WIDTH-1:0] rd_idx_o,
    output logic [isa_defs_pkg::REG_IDX_WIDTH-1:0] rs_idx_o,
    output logic [isa_defs_pkg::REG_IDX_WIDTH-1:0] wr_idx_o,
    output logic                                   wr_en_o,
    output logic [DATA_WIDTH-1:0]                  wr_data_o,
    output arch_defs_pkg::alu_op_t                 alu_op_o,
    output logic                                   carry_in_o,
    output logic                                   result_valid_o,
    output logic                                   zero_o,
    output logic                                   carry_o,
    output logic                                   negative_o
);

    logic is_load;   // Set for a load immediate
    logic alu_fire;  // Accepted ALU instruction this cycle

    // Field decode
    assign alu_op_o = arch_defs_pkg::alu_op_t'(
        instr_i[isa_defs_pkg::OP_MSB:isa_defs_pkg::OP_LSB]);
    assign rd_idx_o = instr_i[isa_defs_pkg::RD_MSB:isa_defs_pkg::RD_LSB];
    assign rs_idx_o = instr_i[isa_defs_pkg::RS_MSB:isa_defs_pkg::RS_LSB];
    assign is_load  = instr_i[isa_defs_pkg::KIND_BIT];

    assign alu_fire = instr_valid_i & ~is_load;

    // Both kinds write rd; only the data source differs
    assign wr_en_o   = instr_valid_i;
    assign wr_idx_o  = rd_idx_o;
    assign wr_data_o = is_load ? imm_i : alu_result_i;

    // Stored carry goes back to the ALU for ADC
    assign carry_in_o = carry_o;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid_o <= 1'b0;
            zero_o         <= 1'b0;
            carry_o        <= 1'b0;
            negative_o     <= 1'b0;
        end else begin
            result_valid_o <= alu_fire; // One cycle high per ALU instruction
            if (alu_fire) begin
                zero_o     <= alu_zero_i;
                carry_o    <= alu_carry_i;
                negative_o <= alu_negative_i;
            end
        end
    end

    // Latched zero and negative must agree with the value written back
    a_flags_match_result: assert property (@(posedge clk) disable iff (reset)
        alu_fire |=> (zero_o == ($past(wr_data_o) == '0))
                     && (negative_o == $past(wr_data_o[DATA_WIDTH-1])))
        else $error("exec_ctrl: flags disagree with the written result");

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`default_nettype none

module reg_file #(
    parameter int DATA_WIDTH = arch_defs_pkg::DATA_WIDTH
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [isa_defs_pkg::REG_IDX_WIDTH-1:0] rd_idx_i,
    input  logic [isa_defs_pkg::REG_IDX_WIDTH-1:0] rs_idx_i,
    input  logic [isa_defs_pkg::REG_IDX_WIDTH-1:0] wr_idx_i,
    input  logic                                  wr_en_i,
    input  logic [DATA_WIDTH-1:0]                 wr_data_i,
    output logic [DATA_WIDTH-1:0]                 rd_data_o,
    output logic [DATA_WIDTH-1:0]                 rs_data_o
);

    // Register count follows from the index field
    localparam int NUM_REGS = 1 << isa_defs_pkg::REG_IDX_WIDTH;

    logic [DATA_WIDTH-1:0] regs_q [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs_q[wr_idx_i] <= wr_data_i;
        end
    end

    // Both read ports are combinational.
    // A write at edge N is seen by the instruction at edge N+1
    assign rd_data_o = regs_q[rd_idx_i];
    assign rs_data_o = regs_q[rs_idx_i];

    // The decoder in exec_ctrl must never hand over a floating write index
    a_wr_idx_known: assert property (@(posedge clk) disable iff (reset)
        wr_en_i |-> !$isunknown(wr_idx_i))
        else $error("reg_file: unknown write index with write enable");

endmodule

`default_nettype wire

// File: logic/alu.sv
`default_nettype none

module alu #(
    parameter int DATA_WIDTH = arch_defs_pkg::DATA_WIDTH
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [DATA_WIDTH-1:0]  in_one_i,
    input  logic [DATA_WIDTH-1:0]  in_two_i,
    input  logic                   in_carry_i,
    input  arch_defs_pkg::alu_op_t alu_op_i,
    output logic [DATA_WIDTH-1:0]  result_o,
    output logic [DATA_WIDTH-1:0]  latched_result_o,
    output logic                   zero_o,
    output logic                   carry_o,
    output logic                   negative_o
);

    localparam logic [DATA_WIDTH:0] ONE_EXT = {{DATA_WIDTH{1'b0}}, 1'b1};

    logic [DATA_WIDTH:0]   op_a_ext;   // Operands widened by one bit for carry out
    logic [DATA_WIDTH:0]   op_b_ext;
    logic [DATA_WIDTH:0]   carry_ext;
    logic [DATA_WIDTH:0]   arith_ext;
    logic [DATA_WIDTH-1:0] logic_res;
    logic                  is_arith;

    assign op_a_ext  = {1'b0, in_one_i};
    assign op_b_ext  = {1'b0, in_two_i};
    assign carry_ext = {{DATA_WIDTH{1'b0}}, in_carry_i};

    always_comb begin
        arith_ext = '0;
        logic_res = '0;
        case (alu_op_i)
            arch_defs_pkg::ALU_ADD: arith_ext = op_a_ext + op_b_ext;
            arch_defs_pkg::ALU_ADC: arith_ext = op_a_ext + op_b_ext + carry_ext;
            // Two's complement subtract where carry set means no borrow
            arch_defs_pkg::ALU_SUB: arith_ext = op_a_ext + {1'b0, ~in_two_i} + ONE_EXT;
            arch_defs_pkg::ALU_INR: arith_ext = op_a_ext + ONE_EXT;
            arch_defs_pkg::ALU_DCR: arith_ext = op_a_ext - ONE_EXT; // Wraps to 1_1111_1111 from 0
            arch_defs_pkg::ALU_AND: logic_res = in_one_i & in_two_i;
            arch_defs_pkg::ALU_OR:  logic_res = in_one_i | in_two_i;
            arch_defs_pkg::ALU_XOR: logic_res = in_one_i ^ in_two_i;
            default: begin
                arith_ext = '0;
                logic_res = '0;
            end
        endcase
    end

    assign is_arith = alu_op_i inside {arch_defs_pkg::ALU_ADD, arch_defs_pkg::ALU_ADC,
                                       arch_defs_pkg::ALU_SUB, arch_defs_pkg::ALU_INR,
                                       arch_defs_pkg::ALU_DCR};

    // Combinational result feeds same-edge write-back
    assign result_o   = is_arith ? arith_ext[DATA_WIDTH-1:0] : logic_res;
    assign carry_o    = is_arith & arith_ext[DATA_WIDTH]; // Logic ops clear carry
    assign zero_o     = (result_o == '0);
    assign negative_o = result_o[DATA_WIDTH-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            latched_result_o <= '0;
        end else begin
            latched_result_o <= result_o; // Follows the ALU every cycle
        end
    end

    // Known inputs must give a known latched value on the next edge
    a_result_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({in_one_i, in_two_i, in_carry_i, alu_op_i})
            |=> !$isunknown(latched_result_o))
        else $error("alu: unknown result from known operands");

endmodule

`default_nettype wire

// File: logic/isa_defs_pkg.sv
`default_nettype none

package isa_defs_pkg;

    // One instruction word per valid strobe
    localparam int INSTR_WIDTH = 8;

    // Two index bits address the four registers
    localparam int REG_IDX_WIDTH = 2;

    // Operation field, maps straight onto arch_defs_pkg::alu_op_t
    localparam int OP_MSB = 7;
    localparam int OP_LSB = 5;

    // Destination register, also the first operand
    localparam int RD_MSB = 4;
    localparam int RD_LSB = 3;

    // Source register, second operand
    localparam int RS_MSB = 2;
    localparam int RS_LSB = 1;

    // Kind bit
    //   0 : ALU instruction, rd <= f(rd, rs)
    //   1 : load immediate, rd <= imm
    localparam int KIND_BIT = 0;

endpackage

`default_nettype wire

// File: logic/arch_defs_pkg.sv
`default_nettype none

package arch_defs_pkg;

    // Operand width of the execute datapath
    localparam int DATA_WIDTH = 8;

    // ALU operation codes, 3 bits wide to fit the opcode field
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0, // rd + rs
        ALU_ADC = 3'd1, // rd + rs + stored carry
        ALU_SUB = 3'd2, // rd + ~rs + 1
        ALU_INR = 3'd3, // rd + 1
        ALU_DCR = 3'd4, // rd - 1
        ALU_AND = 3'd5,
        ALU_OR  = 3'd6,
        ALU_XOR = 3'd7
    } alu_op_t;

    // Arithmetic ops produce a real carry out of the extended sum.
    // Logic ops always clear carry

endpackage

`default_nettype wire
